// File: include/eth_mac_macros.svh
`ifndef ETH_MAC_MACROS_SVH
`define ETH_MAC_MACROS_SVH

// ---------------------------------------------------------------------------
// buffer sizing
// ---------------------------------------------------------------------------
`define ETH_MAX_FRAME_BYTES 402           // bytes per slot, FCS included on rx
`define ETH_TX_SLOTS        4
`define ETH_RX_SLOTS        4

// ---------------------------------------------------------------------------
// GMII framing
// ---------------------------------------------------------------------------
`define ETH_PREAMBLE_BYTE   8'h55
`define ETH_SFD_BYTE        8'hD5
`define ETH_PREAMBLE_LEN    7
`define ETH_FCS_LEN         4
`define ETH_CRC_RESIDUE     32'hC704DD7B  // remainder over payload plus good FCS
`define ETH_IFG_CYCLES      12

`endif

// File: design/eth_frame_pkg.sv
`default_nettype none

package eth_frame_pkg;

	typedef logic [7:0]  gmii_byte_t;
	typedef logic [31:0] crc32_t;

	typedef struct packed {
		gmii_byte_t data;
		logic       en;
		logic       er;
	} gmii_tx_t;

	typedef struct packed {
		gmii_byte_t data;
		logic       dv;
		logic       er;
	} gmii_rx_t;

	typedef enum logic [2:0] {
		TX_IDLE,
		TX_PREAMBLE,
		TX_SFD,
		TX_DATA,
		TX_FCS,
		TX_GAP
	} tx_state_e;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_PREAMBLE,
		RX_DATA,
		RX_DROP                           // wait for dv low, frame is lost
	} rx_state_e;

endpackage

`default_nettype wire

// File: design/eth_host_pkg.sv
`default_nettype none

`include "eth_mac_macros.svh"

package eth_host_pkg;

	typedef logic [$clog2(`ETH_MAX_FRAME_BYTES)-1:0] frame_addr_t;
	typedef logic [$clog2(`ETH_MAX_FRAME_BYTES)-1:0] frame_len_t;

	// host command codes
	typedef enum logic [2:0] {
		READ       = 3'd0,                // byte of oldest rx frame
		READ_LEN   = 3'd1,
		READ_NEXT  = 3'd2,                // free oldest rx frame
		WRITE      = 3'd3,                // byte into open tx slot
		WRITE_LEN  = 3'd4,
		WRITE_NEXT = 3'd5                 // hand open tx slot to the framer
	} host_op_e;

	typedef struct packed {
		host_op_e                  op;
		frame_addr_t               addr;
		eth_frame_pkg::gmii_byte_t data;
	} host_req_t;

	typedef logic [15:0] host_result_t;

endpackage

`default_nettype wire

// File: design/crc32_d8.sv
`timescale 1ns/1ps
`default_nettype none

module crc32_d8 (
	input  eth_frame_pkg::gmii_byte_t data_i,
	input  eth_frame_pkg::crc32_t     crc_i,
	output eth_frame_pkg::crc32_t     crc_o
);

	// x^32 + x^26 + x^23 + x^22 + x^16 + x^12 + x^11 + x^10 + x^8 + x^7 + x^5 + x^4 + x^2 + x + 1
	localparam eth_frame_pkg::crc32_t POLY = 32'h04C11DB7;

	eth_frame_pkg::crc32_t c;
	logic                  fb;

	// unrolled into the xor network, d[0] is the first bit on the wire
	always_comb begin
		c  = crc_i;
		fb = 1'b0;
		for (int i = 0; i < 8; i++) begin
			fb = c[31] ^ data_i[i];
			c  = {c[30:0], 1'b0} ^ (fb ? POLY : '0);
		end
		crc_o = c;
	end

endmodule

`default_nettype wire

// File: design/packet_ring.sv
`timescale 1ns/1ps
`default_nettype none

`include "eth_mac_macros.svh"

module packet_ring #(
	parameter int SLOTS = 4
) (
	input  logic                      clock,
	input  logic                      reset,
	// producer side
	input  logic                      wr_i,
	input  eth_host_pkg::frame_addr_t wr_addr_i,
	input  eth_frame_pkg::gmii_byte_t wr_data_i,
	input  logic                      commit_i,
	input  logic                      discard_i,
	output logic                      full_o,
	output eth_host_pkg::frame_len_t  open_len_o,
	// consumer side
	input  eth_host_pkg::frame_addr_t rd_addr_i,
	output eth_frame_pkg::gmii_byte_t rd_data_o,
	output eth_host_pkg::frame_len_t  head_len_o,
	output logic                      empty_o,
	input  logic                      release_i
);

	// SLOTS committed frames plus the one being filled
	localparam int DEPTH = SLOTS + 1;
	localparam int PW    = $clog2(DEPTH);

	eth_frame_pkg::gmii_byte_t mem [DEPTH][`ETH_MAX_FRAME_BYTES];
	eth_host_pkg::frame_len_t  len [DEPTH];

	logic [PW-1:0] head;                  // oldest committed slot
	logic [PW-1:0] tail;                  // open slot
	logic [PW-1:0] count;                 // committed slots
	logic          push;
	logic          pop;

	function automatic logic [PW-1:0] step(input logic [PW-1:0] p);
		return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign full_o  = (count == PW'(SLOTS));
	assign empty_o = (count == '0);
	assign push    = commit_i && !full_o;
	assign pop     = release_i && !empty_o;

	// ---------------------------------------------------------------------------
	// storage
	// ---------------------------------------------------------------------------
	always_ff @(posedge clock) begin
		if (wr_i)
			mem[tail][wr_addr_i] <= wr_data_i;
		if (push)
			len[tail] <= open_len_o;      // length frozen at commit
	end

	assign head_len_o = empty_o ? '0 : len[head];
	assign rd_data_o  = (rd_addr_i < head_len_o) ? mem[head][rd_addr_i] : '0;

	// ---------------------------------------------------------------------------
	// pointers and open length
	// ---------------------------------------------------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			head       <= '0;
			tail       <= '0;
			count      <= '0;
			open_len_o <= '0;
		end else begin
			if (push) begin
				tail       <= step(tail);
				open_len_o <= '0;         // next slot starts empty
			end else if (discard_i) begin
				open_len_o <= '0;
			end else if (wr_i && wr_addr_i >= open_len_o) begin
				open_len_o <= wr_addr_i + 1'b1;
			end

			if (pop)
				head <= step(head);

			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// producer never commits into a full ring
	a_no_overrun: assert property (@(posedge clock) disable iff (reset)
		commit_i |-> !full_o);

	// consumer never releases from an empty ring
	a_no_underrun: assert property (@(posedge clock) disable iff (reset)
		release_i |-> !empty_o);

endmodule

`default_nettype wire

// File: design/gmii_tx_framer.sv
`timescale 1ns/1ps
`default_nettype none

`include "eth_mac_macros.svh"

module gmii_tx_framer (
	input  logic                      clock,
	input  logic                      reset,
	output eth_frame_pkg::gmii_tx_t   tx_o,
	input  logic                      ring_empty_i,
	input  eth_host_pkg::frame_len_t  ring_len_i,
	output eth_host_pkg::frame_addr_t ring_addr_o,
	input  eth_frame_pkg::gmii_byte_t ring_data_i,
	output logic                      ring_release_o
);

	eth_frame_pkg::tx_state_e  state;
	eth_frame_pkg::crc32_t     crc;
	eth_frame_pkg::crc32_t     crc_next;
	eth_host_pkg::frame_addr_t addr;      // next payload byte
	logic [3:0]                cnt;       // preamble, fcs and gap counter

	// top crc byte complemented and bit reversed
	function automatic eth_frame_pkg::gmii_byte_t fcs_byte(input eth_frame_pkg::crc32_t c);
		eth_frame_pkg::gmii_byte_t b;
		for (int i = 0; i < 8; i++)
			b[i] = ~c[31 - i];
		return b;
	endfunction

	crc32_d8 u_crc (
		.data_i (ring_data_i),
		.crc_i  (crc),
		.crc_o  (crc_next)
	);

	assign ring_addr_o    = addr;
	assign ring_release_o = (state == eth_frame_pkg::TX_FCS) && (cnt == 4'(`ETH_FCS_LEN));

	always_ff @(posedge clock) begin
		if (reset) begin
			state   <= eth_frame_pkg::TX_IDLE;
			cnt     <= '0;
			tx_o.en <= 1'b0;
			tx_o.er <= 1'b0;
		end else begin
			case (state)
				eth_frame_pkg::TX_IDLE: begin
					if (!ring_empty_i) begin
						tx_o.data <= `ETH_PREAMBLE_BYTE;
						tx_o.en   <= 1'b1;
						cnt       <= 4'd1;
						state     <= eth_frame_pkg::TX_PREAMBLE;
					end
				end
				eth_frame_pkg::TX_PREAMBLE: begin
					if (cnt == 4'(`ETH_PREAMBLE_LEN)) begin
						tx_o.data <= `ETH_SFD_BYTE;
						addr      <= '0;
						crc       <= '1;  // crc preset
						state     <= eth_frame_pkg::TX_SFD;
					end else begin
						tx_o.data <= `ETH_PREAMBLE_BYTE;
						cnt       <= cnt + 1'b1;
					end
				end
				eth_frame_pkg::TX_SFD: begin
					tx_o.data <= ring_data_i;     // first payload byte
					crc       <= crc_next;
					addr      <= addr + 1'b1;
					state     <= eth_frame_pkg::TX_DATA;
				end
				eth_frame_pkg::TX_DATA: begin
					if (addr < ring_len_i) begin
						tx_o.data <= ring_data_i;
						crc       <= crc_next;
						addr      <= addr + 1'b1;
					end else begin
						tx_o.data <= fcs_byte(crc);
						crc       <= crc << 8;
						cnt       <= 4'd1;
						state     <= eth_frame_pkg::TX_FCS;
					end
				end
				eth_frame_pkg::TX_FCS: begin
					if (cnt == 4'(`ETH_FCS_LEN)) begin
						tx_o.data <= '0;
						tx_o.en   <= 1'b0;
						cnt       <= 4'd1;
						state     <= eth_frame_pkg::TX_GAP;
					end else begin
						tx_o.data <= fcs_byte(crc);
						crc       <= crc << 8;
						cnt       <= cnt + 1'b1;
					end
				end
				eth_frame_pkg::TX_GAP: begin
					if (cnt == 4'(`ETH_IFG_CYCLES))
						state <= eth_frame_pkg::TX_IDLE;
					else
						cnt <= cnt + 1'b1;
				end
				default: state <= eth_frame_pkg::TX_IDLE;
			endcase
		end
	end

	// the head slot stays in the ring until its last fcs byte is out
	a_slot_held: assert property (@(posedge clock) disable iff (reset)
		!(state inside {eth_frame_pkg::TX_IDLE, eth_frame_pkg::TX_GAP}) |-> !ring_empty_i);

endmodule

`default_nettype wire

// File: design/gmii_rx_deframer.sv
`timescale 1ns/1ps
`default_nettype none

`include "eth_mac_macros.svh"

module gmii_rx_deframer (
	input  logic                      clock,
	input  logic                      reset,
	input  eth_frame_pkg::gmii_rx_t   rx_i,
	output logic                      wr_o,
	output eth_host_pkg::frame_addr_t wr_addr_o,
	output eth_frame_pkg::gmii_byte_t wr_data_o,
	output logic                      commit_o,
	output logic                      discard_o,
	input  logic                      ring_full_i
);

	eth_frame_pkg::rx_state_e  state;
	eth_frame_pkg::crc32_t     crc;
	eth_frame_pkg::crc32_t     crc_next;
	eth_host_pkg::frame_len_t  count;     // bytes after sfd including fcs
	logic [2:0]                pre_cnt;
	logic                      take;
	logic                      frame_ok;

	// bytes trail the wire by the fcs length so the fcs never reaches the ring
	eth_frame_pkg::gmii_byte_t dly [`ETH_FCS_LEN];

	crc32_d8 u_crc (
		.data_i (rx_i.data),
		.crc_i  (crc),
		.crc_o  (crc_next)
	);

	assign take = (state == eth_frame_pkg::RX_DATA) && rx_i.dv && !rx_i.er
		&& (count < `ETH_MAX_FRAME_BYTES);

	assign wr_o      = take && (count >= `ETH_FCS_LEN);
	assign wr_addr_o = eth_host_pkg::frame_addr_t'(count - `ETH_FCS_LEN);
	assign wr_data_o = dly[`ETH_FCS_LEN-1];

	assign frame_ok = (crc == `ETH_CRC_RESIDUE) && (count > `ETH_FCS_LEN) && !ring_full_i;

	// decided in the first cycle with dv low
	assign commit_o  = (state == eth_frame_pkg::RX_DATA) && !rx_i.dv && frame_ok;
	assign discard_o = !rx_i.dv && ((state == eth_frame_pkg::RX_DROP)
		|| ((state == eth_frame_pkg::RX_DATA) && !frame_ok));

	always_ff @(posedge clock) begin
		if (take) begin
			crc    <= crc_next;
			dly[0] <= rx_i.data;
			for (int i = 1; i < `ETH_FCS_LEN; i++)
				dly[i] <= dly[i-1];
		end else if (state != eth_frame_pkg::RX_DATA) begin
			crc <= '1;                    // preset while waiting for the sfd
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state   <= eth_frame_pkg::RX_IDLE;
			pre_cnt <= '0;
			count   <= '0;
		end else begin
			case (state)
				eth_frame_pkg::RX_IDLE: begin
					if (rx_i.dv) begin
						if (!rx_i.er && rx_i.data == `ETH_PREAMBLE_BYTE) begin
							pre_cnt <= 3'd1;
							state   <= eth_frame_pkg::RX_PREAMBLE;
						end else begin
							state <= eth_frame_pkg::RX_DROP;
						end
					end
				end
				eth_frame_pkg::RX_PREAMBLE: begin
					if (!rx_i.dv)
						state <= eth_frame_pkg::RX_IDLE;
					else if (rx_i.er)
						state <= eth_frame_pkg::RX_DROP;
					else if (rx_i.data == `ETH_PREAMBLE_BYTE && pre_cnt < `ETH_PREAMBLE_LEN)
						pre_cnt <= pre_cnt + 1'b1;
					else if (rx_i.data == `ETH_SFD_BYTE && pre_cnt == `ETH_PREAMBLE_LEN) begin
						count <= '0;
						state <= eth_frame_pkg::RX_DATA;
					end else
						state <= eth_frame_pkg::RX_DROP;
				end
				eth_frame_pkg::RX_DATA: begin
					if (!rx_i.dv)
						state <= eth_frame_pkg::RX_IDLE;
					else if (take)
						count <= count + 1'b1;
					else
						state <= eth_frame_pkg::RX_DROP;  // er or oversize
				end
				eth_frame_pkg::RX_DROP: begin
					if (!rx_i.dv)
						state <= eth_frame_pkg::RX_IDLE;
				end
				default: state <= eth_frame_pkg::RX_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/eth_mac_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "eth_mac_macros.svh"

module eth_mac_top (
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       start_i,
	input  eth_host_pkg::host_req_t    req_i,
	output logic                       done_o,
	output eth_host_pkg::host_result_t result_o,
	output eth_frame_pkg::gmii_tx_t    gmii_tx_o,
	input  eth_frame_pkg::gmii_rx_t    gmii_rx_i
);

	logic                       tx_wr;
	logic                       tx_commit;
	logic                       tx_full;
	logic                       tx_empty;
	logic                       tx_release;
	eth_host_pkg::frame_len_t   tx_open_len;
	eth_host_pkg::frame_len_t   tx_head_len;
	eth_host_pkg::frame_addr_t  tx_rd_addr;
	eth_frame_pkg::gmii_byte_t  tx_rd_data;

	logic                       rx_wr;
	logic                       rx_commit;
	logic                       rx_discard;
	logic                       rx_full;
	logic                       rx_empty;
	logic                       rx_release;
	eth_host_pkg::frame_addr_t  rx_wr_addr;
	eth_frame_pkg::gmii_byte_t  rx_wr_data;
	eth_frame_pkg::gmii_byte_t  rx_rd_data;
	eth_host_pkg::frame_len_t   rx_head_len;

	logic                       addr_ok;
	eth_host_pkg::host_result_t result_d;

	// ---------------------------------------------------------------------------
	// host command decode
	// ---------------------------------------------------------------------------
	assign addr_ok    = req_i.addr < `ETH_MAX_FRAME_BYTES;
	assign tx_wr      = start_i && req_i.op == eth_host_pkg::WRITE && addr_ok;
	assign tx_commit  = start_i && req_i.op == eth_host_pkg::WRITE_NEXT
		&& !tx_full && tx_open_len != '0;  // empty slot is never sent
	assign rx_release = start_i && req_i.op == eth_host_pkg::READ_NEXT && !rx_empty;

	always_comb begin
		case (req_i.op)
			eth_host_pkg::READ:       result_d = eth_host_pkg::host_result_t'(rx_rd_data);
			eth_host_pkg::READ_LEN:   result_d = eth_host_pkg::host_result_t'(rx_head_len);
			eth_host_pkg::READ_NEXT:  result_d = eth_host_pkg::host_result_t'(rx_empty);
			eth_host_pkg::WRITE:      result_d = eth_host_pkg::host_result_t'(!addr_ok);
			eth_host_pkg::WRITE_LEN:  result_d = eth_host_pkg::host_result_t'(tx_open_len);
			eth_host_pkg::WRITE_NEXT: result_d = eth_host_pkg::host_result_t'(tx_full);
			default:                  result_d = '0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset)
			done_o <= 1'b0;
		else
			done_o <= start_i;
	end

	always_ff @(posedge clock) begin
		if (start_i)
			result_o <= result_d;
	end

	// ---------------------------------------------------------------------------
	// rings and framers
	// ---------------------------------------------------------------------------
	packet_ring #(.SLOTS(`ETH_TX_SLOTS)) tx_ring (
		.clock      (clock),
		.reset      (reset),
		.wr_i       (tx_wr),
		.wr_addr_i  (req_i.addr),
		.wr_data_i  (req_i.data),
		.commit_i   (tx_commit),
		.discard_i  (1'b0),               // host has no abort command
		.full_o     (tx_full),
		.open_len_o (tx_open_len),
		.rd_addr_i  (tx_rd_addr),
		.rd_data_o  (tx_rd_data),
		.head_len_o (tx_head_len),
		.empty_o    (tx_empty),
		.release_i  (tx_release)
	);

	packet_ring #(.SLOTS(`ETH_RX_SLOTS)) rx_ring (
		.clock      (clock),
		.reset      (reset),
		.wr_i       (rx_wr),
		.wr_addr_i  (rx_wr_addr),
		.wr_data_i  (rx_wr_data),
		.commit_i   (rx_commit),
		.discard_i  (rx_discard),
		.full_o     (rx_full),
		.open_len_o (),
		.rd_addr_i  (req_i.addr),
		.rd_data_o  (rx_rd_data),
		.head_len_o (rx_head_len),
		.empty_o    (rx_empty),
		.release_i  (rx_release)
	);

	gmii_tx_framer u_tx (
		.clock          (clock),
		.reset          (reset),
		.tx_o           (gmii_tx_o),
		.ring_empty_i   (tx_empty),
		.ring_len_i     (tx_head_len),
		.ring_addr_o    (tx_rd_addr),
		.ring_data_i    (tx_rd_data),
		.ring_release_o (tx_release)
	);

	gmii_rx_deframer u_rx (
		.clock       (clock),
		.reset       (reset),
		.rx_i        (gmii_rx_i),
		.wr_o        (rx_wr),
		.wr_addr_o   (rx_wr_addr),
		.wr_data_o   (rx_wr_data),
		.commit_o    (rx_commit),
		.discard_o   (rx_discard),
		.ring_full_i (rx_full)
	);

	// one-cycle done, host waits a cycle before its next start
	a_done_pulse: assert property (@(posedge clock) disable iff (reset)
		done_o |=> !done_o);

endmodule

`default_nettype wire

// File: testbench/tb_eth_mac.sv
`timescale 1ns/1ps
`default_nettype none

`include "eth_mac_macros.svh"

module tb_eth_mac;

	typedef eth_frame_pkg::gmii_byte_t byte_q_t [$];

	localparam int CMD_TIMEOUT = 8;        // cycles until done_o
	localparam int TX_TIMEOUT  = 200;      // cycles until tx en rises
	localparam int WIRE_LIMIT  = `ETH_MAX_FRAME_BYTES + 16;

	logic                       clock;
	logic                       reset;
	logic                       start;
	eth_host_pkg::host_req_t    req;
	logic                       done;
	eth_host_pkg::host_result_t result;
	eth_frame_pkg::gmii_tx_t    gmii_tx;
	eth_frame_pkg::gmii_rx_t    gmii_rx;
	integer                     seed;

	eth_mac_top uut (
		.clock     (clock),
		.reset     (reset),
		.start_i   (start),
		.req_i     (req),
		.done_o    (done),
		.result_o  (result),
		.gmii_tx_o (gmii_tx),
		.gmii_rx_i (gmii_rx)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// ---------------------------------------------------------------------------
	// error reporting and compare tasks
	// ---------------------------------------------------------------------------
	task automatic fail_run();
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic report_mismatch(input string msg);
		$display("** Error at %0t ns: %s", $time, msg);
		fail_run();
	endtask

	task automatic report_timeout(input string what);
		$display("timeout while waiting for %s", what);
		fail_run();
	endtask

	task automatic check_result(input eth_host_pkg::host_result_t got,
		input eth_host_pkg::host_result_t exp, input string what);
		if (got !== exp)
			report_mismatch($sformatf("%s: got 0x%04h, expected 0x%04h", what, got, exp));
	endtask

	task automatic check_byte(input eth_frame_pkg::gmii_byte_t got,
		input eth_frame_pkg::gmii_byte_t exp, input string what);
		if (got !== exp)
			report_mismatch($sformatf("%s: got 0x%02h, expected 0x%02h", what, got, exp));
	endtask

	task automatic check_len(input eth_host_pkg::frame_len_t got,
		input eth_host_pkg::frame_len_t exp, input string what);
		if (got !== exp)
			report_mismatch($sformatf("%s: got %0d, expected %0d", what, got, exp));
	endtask

	// ---------------------------------------------------------------------------
	// reference model and bus helpers
	// ---------------------------------------------------------------------------
	// reflected crc-32 with the fcs sent low byte first
	function automatic eth_frame_pkg::crc32_t ref_fcs(input byte_q_t data);
		eth_frame_pkg::crc32_t r;
		r = 32'hFFFFFFFF;
		foreach (data[i]) begin
			r = r ^ {24'h0, data[i]};
			for (int b = 0; b < 8; b++)
				r = r[0] ? ((r >> 1) ^ 32'hEDB88320) : (r >> 1);
		end
		return ~r;
	endfunction

	task automatic make_payload(input int n, output byte_q_t q);
		q = {};
		for (int i = 0; i < n; i++)
			q.push_back(eth_frame_pkg::gmii_byte_t'($random(seed)));
	endtask

	task automatic host_cmd(input eth_host_pkg::host_op_e op,
		input eth_host_pkg::frame_addr_t addr, input eth_frame_pkg::gmii_byte_t data,
		output eth_host_pkg::host_result_t res);
		int cycles;
		@(negedge clock);
		start    = 1'b1;
		req.op   = op;
		req.addr = addr;
		req.data = data;
		cycles   = 0;
		@(negedge clock);
		start = 1'b0;                     // one edge per command
		while (done !== 1'b1) begin
			cycles++;
			if (cycles > CMD_TIMEOUT)
				report_timeout("done_o after a host command");
			@(negedge clock);
		end
		res = result;
	endtask

	task automatic send_gmii_frame(input byte_q_t payload, input bit bad_fcs,
		input int er_at);
		byte_q_t               octets;
		eth_frame_pkg::crc32_t fcs;
		fcs = ref_fcs(payload);
		if (bad_fcs)
			fcs[23:16] = ~fcs[23:16];     // third fcs byte spoiled
		octets = {};
		for (int i = 0; i < `ETH_PREAMBLE_LEN; i++)
			octets.push_back(`ETH_PREAMBLE_BYTE);
		octets.push_back(`ETH_SFD_BYTE);
		foreach (payload[i])
			octets.push_back(payload[i]);
		for (int i = 0; i < `ETH_FCS_LEN; i++)
			octets.push_back(fcs[8*i +: 8]);
		foreach (octets[i]) begin
			@(negedge clock);
			gmii_rx.data = octets[i];
			gmii_rx.dv   = 1'b1;
			gmii_rx.er   = (i == er_at);
		end
		@(negedge clock);
		gmii_rx = '0;
		repeat (`ETH_IFG_CYCLES) @(negedge clock);
	endtask

	task automatic write_tx_frame(input byte_q_t payload);
		eth_host_pkg::host_result_t res;
		foreach (payload[i]) begin
			host_cmd(eth_host_pkg::WRITE, eth_host_pkg::frame_addr_t'(i), payload[i], res);
			check_result(res, '0, "WRITE status");
		end
		host_cmd(eth_host_pkg::WRITE_LEN, '0, '0, res);
		check_len(eth_host_pkg::frame_len_t'(res),
			eth_host_pkg::frame_len_t'(payload.size()), "WRITE_LEN");
		host_cmd(eth_host_pkg::WRITE_NEXT, '0, '0, res);
		check_result(res, '0, "WRITE_NEXT status");
	endtask

	task automatic capture_tx_frame(output byte_q_t frame);
		int cycles;
		frame  = {};
		cycles = 0;
		while (!gmii_tx.en) begin
			cycles++;
			if (cycles > TX_TIMEOUT)
				report_timeout("tx en to rise");
			@(negedge clock);
		end
		cycles = 0;
		while (gmii_tx.en) begin
			frame.push_back(gmii_tx.data);
			if (gmii_tx.er !== 1'b0)
				report_mismatch("tx er high inside a frame");
			cycles++;
			if (cycles > WIRE_LIMIT)
				report_timeout("tx en to fall");
			@(negedge clock);
		end
	endtask

	task automatic check_tx_frame(input byte_q_t payload, input byte_q_t frame);
		eth_frame_pkg::crc32_t fcs;
		int                    n;
		n = payload.size();
		check_len(eth_host_pkg::frame_len_t'(frame.size()),
			eth_host_pkg::frame_len_t'(n + `ETH_PREAMBLE_LEN + 1 + `ETH_FCS_LEN),
			"tx frame length on the wire");
		for (int i = 0; i < `ETH_PREAMBLE_LEN; i++)
			check_byte(frame[i], `ETH_PREAMBLE_BYTE, $sformatf("preamble byte %0d", i));
		check_byte(frame[`ETH_PREAMBLE_LEN], `ETH_SFD_BYTE, "sfd");
		for (int i = 0; i < n; i++)
			check_byte(frame[8 + i], payload[i], $sformatf("tx payload byte %0d", i));
		fcs = ref_fcs(payload);
		for (int i = 0; i < `ETH_FCS_LEN; i++)
			check_byte(frame[8 + n + i], fcs[8*i +: 8], $sformatf("tx fcs byte %0d", i));
	endtask

	task automatic read_rx_frame(input byte_q_t payload);
		eth_host_pkg::host_result_t res;
		host_cmd(eth_host_pkg::READ_LEN, '0, '0, res);
		check_len(eth_host_pkg::frame_len_t'(res),
			eth_host_pkg::frame_len_t'(payload.size()), "READ_LEN");
		foreach (payload[i]) begin
			host_cmd(eth_host_pkg::READ, eth_host_pkg::frame_addr_t'(i), '0, res);
			check_byte(eth_frame_pkg::gmii_byte_t'(res), payload[i], $sformatf("READ %0d", i));
		end
		host_cmd(eth_host_pkg::READ, eth_host_pkg::frame_addr_t'(payload.size()), '0, res);
		check_result(res, '0, "READ past the frame length");
		host_cmd(eth_host_pkg::READ_NEXT, '0, '0, res);
		check_result(res, '0, "READ_NEXT on a stored frame");
	endtask

	// ---------------------------------------------------------------------------
	// directed tests
	// ---------------------------------------------------------------------------
	task automatic test_reset_state();
		eth_host_pkg::host_result_t res;
		if (done !== 1'b0)
			report_mismatch("done_o not low after reset");
		if (gmii_tx.en !== 1'b0 || gmii_tx.er !== 1'b0)
			report_mismatch("tx en or er not low after reset");
		host_cmd(eth_host_pkg::READ_LEN, '0, '0, res);
		check_result(res, '0, "READ_LEN after reset");
		host_cmd(eth_host_pkg::READ_NEXT, '0, '0, res);
		check_result(res, 16'd1, "READ_NEXT on an empty ring");
		host_cmd(eth_host_pkg::WRITE, eth_host_pkg::frame_addr_t'(`ETH_MAX_FRAME_BYTES),
			8'hA5, res);
		check_result(res, 16'd1, "WRITE beyond the slot");
	endtask

	task automatic test_tx_single();
		byte_q_t payload;
		byte_q_t frame;
		make_payload(20, payload);
		write_tx_frame(payload);
		capture_tx_frame(frame);
		check_tx_frame(payload, frame);
	endtask

	task automatic test_tx_back_to_back();
		byte_q_t first;
		byte_q_t second;
		byte_q_t frame_a;
		byte_q_t frame_b;
		int      gap;
		make_payload(40, first);
		make_payload(8, second);
		write_tx_frame(first);
		fork
			begin
				capture_tx_frame(frame_a);
				gap = 0;
				while (!gmii_tx.en) begin
					gap++;
					if (gap > TX_TIMEOUT)
						report_timeout("the second tx frame");
					@(negedge clock);
				end
				capture_tx_frame(frame_b);
			end
			write_tx_frame(second);       // committed while the first is on the wire
		join
		check_tx_frame(first, frame_a);
		check_tx_frame(second, frame_b);
		if (gap < `ETH_IFG_CYCLES)
			report_mismatch($sformatf("inter-frame gap of %0d cycles, expected at least %0d",
				gap, `ETH_IFG_CYCLES));
	endtask

	task automatic test_rx_good();
		byte_q_t                    payload;
		eth_host_pkg::host_result_t res;
		make_payload(30, payload);
		send_gmii_frame(payload, 1'b0, -1);
		read_rx_frame(payload);
		host_cmd(eth_host_pkg::READ_LEN, '0, '0, res);
		check_result(res, '0, "READ_LEN after READ_NEXT");
	endtask

	task automatic test_rx_errors();
		byte_q_t                    payload;
		eth_host_pkg::host_result_t res;
		make_payload(25, payload);
		send_gmii_frame(payload, 1'b1, -1);
		host_cmd(eth_host_pkg::READ_LEN, '0, '0, res);
		check_result(res, '0, "READ_LEN after a bad fcs");
		send_gmii_frame(payload, 1'b0, `ETH_PREAMBLE_LEN + 1 + 5);
		host_cmd(eth_host_pkg::READ_LEN, '0, '0, res);
		check_result(res, '0, "READ_LEN after rx er");
	endtask

	task automatic test_rx_overflow();
		byte_q_t                    frames [5];
		eth_host_pkg::host_result_t res;
		for (int i = 0; i < 5; i++) begin
			make_payload(10 + i, frames[i]);
			send_gmii_frame(frames[i], 1'b0, -1);
		end
		for (int i = 0; i < `ETH_RX_SLOTS; i++)
			read_rx_frame(frames[i]);     // fifth frame was dropped
		host_cmd(eth_host_pkg::READ_NEXT, '0, '0, res);
		check_result(res, 16'd1, "READ_NEXT after the ring drained");
	endtask

	// ---------------------------------------------------------------------------
	// main sequence
	// ---------------------------------------------------------------------------
	initial begin
		seed    = 9526;
		reset   = 1'b1;
		start   = 1'b0;
		req     = '0;
		gmii_rx = '0;
		repeat (10) @(negedge clock);
		reset = 1'b0;

		test_reset_state();
		test_tx_single();
		test_tx_back_to_back();
		test_rx_good();
		test_rx_errors();
		test_rx_overflow();

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+include
design/eth_frame_pkg.sv
design/eth_host_pkg.sv
design/crc32_d8.sv
design/packet_ring.sv
design/gmii_tx_framer.sv
design/gmii_rx_deframer.sv
design/eth_mac_top.sv
testbench/tb_eth_mac.sv

// File: Bender.yml
package:
  name: eth_mac

sources:
  - include_dirs:
      - include
    files:
      - design/eth_frame_pkg.sv
      - design/eth_host_pkg.sv
      - design/crc32_d8.sv
      - design/packet_ring.sv
      - design/gmii_tx_framer.sv
      - design/gmii_rx_deframer.sv
      - design/eth_mac_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_eth_mac.sv
